// ==== hw/display_macros.svh ====
`ifndef DISPLAY_MACROS_SVH
`define DISPLAY_MACROS_SVH

// horizontal timing, in pixel clocks
`define H_ACTIVE 640
`define H_FP 16
`define H_SYNC 96
`define H_BP 48
`define H_TOTAL 800

// vertical timing, in lines
`define V_ACTIVE 480
`define V_FP 10
`define V_SYNC 2
`define V_BP 33
`define V_TOTAL 525

// board geometry
`define BOARD_ROWS 20
`define BOARD_COLS 10
`define CELL_PX 16
`define GRID_X0 240
`define GRID_Y0 80

// screen pixels per font pixel
`define FONT_SCALE 4

// apb map
`define APB_ADDR_W 8
`define ADDR_ROW0 'h00
`define ADDR_SCORE 'h20
`define ADDR_SCORE_COLOR 'h21
`define ADDR_SCORE_POS 'h22

`endif

// ==== hw/display_pkg.sv ====
`default_nettype none
`include "display_macros.svh"

package display_pkg;

  // one bit each for red, green, blue; zero is black
  typedef logic [2:0] color_t;

  // column 0 sits in the low bits
  typedef color_t [`BOARD_COLS-1:0] board_row_t;

  // whole settled playfield, row 0 at the top
  typedef board_row_t [`BOARD_ROWS-1:0] board_t;

  // 3x5 hex glyphs
  // row 0 in bits 14:12, msb of each row is the leftmost pixel
  localparam logic [14:0] hex_font [0:15] = '{
    15'b111_101_101_101_111,
    15'b010_110_010_010_111,
    15'b111_001_111_100_111,
    15'b111_001_111_001_111,
    15'b101_101_111_001_001,
    15'b111_100_111_001_111,
    15'b111_100_111_101_111,
    15'b111_001_001_001_001,
    15'b111_101_111_101_111,
    15'b111_101_111_001_111,
    15'b010_101_111_101_101,
    15'b110_101_110_101_110,
    15'b111_100_100_100_111,
    15'b110_101_101_101_110,
    15'b111_100_111_100_111,
    15'b111_100_111_100_100
  };

endpackage

`default_nettype wire

// ==== hw/vga_pixel_if.sv ====
`timescale 1ns/1ps
`default_nettype none

// pixel stage 0: every field describes the same pixel in a cycle
interface vga_pixel_if;

  // screen coordinates from the counters
  logic [9:0] x;
  logic [9:0] y;
  // inside the 640x480 visible area
  logic       active;
  // low-true syncs
  logic       hsync;
  logic       vsync;

  // driven by the timing generator
  modport source (output x, y, active, hsync, vsync);

  // renderers and compositor only look
  modport sink (input x, y, active, hsync, vsync);

endinterface

`default_nettype wire

// ==== hw/vga_timing.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "display_macros.svh"

module vga_timing (
  input  wire logic         clk,
  input  wire logic         rst_n,
  vga_pixel_if.source       pix
);

  // sync pulse windows
  localparam int HS_START = `H_ACTIVE + `H_FP;
  localparam int HS_END   = `H_ACTIVE + `H_FP + `H_SYNC;
  localparam int VS_START = `V_ACTIVE + `V_FP;
  localparam int VS_END   = `V_ACTIVE + `V_FP + `V_SYNC;

  logic [9:0] h_cnt;
  logic [9:0] v_cnt;
  logic       h_last;
  logic       v_last;

  // end of line and end of frame
  assign h_last = (h_cnt == 10'(`H_TOTAL - 1));
  assign v_last = (v_cnt == 10'(`V_TOTAL - 1));

  // one pixel per clock and one line per horizontal wrap
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      h_cnt <= '0;
      v_cnt <= '0;
    end else begin
      h_cnt <= h_last ? '0 : h_cnt + 10'd1;
      if (h_last) begin
        v_cnt <= v_last ? '0 : v_cnt + 10'd1;
      end
    end
  end

  assign pix.x = h_cnt;
  assign pix.y = v_cnt;

  // visible area
  assign pix.active = (h_cnt < 10'(`H_ACTIVE)) && (v_cnt < 10'(`V_ACTIVE));

  // syncs pulse low inside the windows
  assign pix.hsync = !((h_cnt >= 10'(HS_START)) && (h_cnt < 10'(HS_END)));
  assign pix.vsync = !((v_cnt >= 10'(VS_START)) && (v_cnt < 10'(VS_END)));

  // counter stays inside the line
  a_x_range: assert property (@(posedge clk) disable iff (!rst_n)
    pix.x < 10'(`H_TOTAL));

endmodule

`default_nettype wire

// ==== hw/apb_regs.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "display_macros.svh"

module apb_regs (
  input  wire logic                     clk,
  input  wire logic                     rst_n,
  input  wire logic                     psel,
  input  wire logic                     penable,
  input  wire logic                     pwrite,
  input  wire logic [`APB_ADDR_W-1:0]   paddr,
  input  wire logic [31:0]              pwdata,
  output logic      [31:0]              prdata,
  output logic                          pready,
  output logic                          pslverr,
  output display_pkg::board_t           board,
  output logic      [7:0]               score,
  output display_pkg::color_t           score_fg,
  output logic      [13:0]              score_pos
);

  localparam int ROW_W   = $clog2(`BOARD_ROWS);
  localparam int ROW_BITS = $bits(display_pkg::board_row_t);

  logic [`APB_ADDR_W-1:0] row_off;
  logic                   in_rows;
  logic                   is_score;
  logic                   is_color;
  logic                   is_pos;
  logic                   hit;
  logic                   access;

  // address decode
  assign row_off  = paddr - `APB_ADDR_W'(`ADDR_ROW0);
  assign in_rows  = row_off < `APB_ADDR_W'(`BOARD_ROWS);
  assign is_score = paddr == `APB_ADDR_W'(`ADDR_SCORE);
  assign is_color = paddr == `APB_ADDR_W'(`ADDR_SCORE_COLOR);
  assign is_pos   = paddr == `APB_ADDR_W'(`ADDR_SCORE_POS);
  assign hit      = in_rows || is_score || is_color || is_pos;

  // access phase, no wait states
  assign access  = psel && penable;
  assign pready  = 1'b1;
  assign pslverr = access && !hit;

  // writes land on the access edge; unmapped addresses match nothing
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      board     <= '0;
      score     <= '0;
      score_fg  <= '0;
      score_pos <= '0;
    end else if (access && pwrite) begin
      if (in_rows) begin
        board[row_off[ROW_W-1:0]] <= pwdata[ROW_BITS-1:0];
      end
      if (is_score) begin
        score <= pwdata[7:0];
      end
      if (is_color) begin
        score_fg <= pwdata[2:0];
      end
      // column in 5:0, row in 13:8, bits 7:6 unused
      if (is_pos) begin
        score_pos <= {pwdata[13:8], 2'b00, pwdata[5:0]};
      end
    end
  end

  // readback mux, zero for holes in the map
  always_comb begin
    prdata = '0;
    if (in_rows) begin
      prdata = 32'(board[row_off[ROW_W-1:0]]);
    end else if (is_score) begin
      prdata = 32'(score);
    end else if (is_color) begin
      prdata = 32'(score_fg);
    end else if (is_pos) begin
      prdata = 32'(score_pos);
    end
  end

  // access phase only inside a selected transfer
  a_penable_psel: assert property (@(posedge clk) disable iff (!rst_n)
    penable |-> psel);

  // address held from setup into access
  a_paddr_stable: assert property (@(posedge clk) disable iff (!rst_n)
    (psel && !penable) ##1 penable |-> $stable(paddr));

endmodule

`default_nettype wire

// ==== hw/playfield_renderer.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "display_macros.svh"

module playfield_renderer (
  input  wire logic                 clk,
  input  wire logic                 rst_n,
  vga_pixel_if.sink                 pix,
  input  wire display_pkg::board_t  board,
  output display_pkg::color_t       grid_color
);

  // cell index widths and shift for the cell edge
  localparam int COL_W   = $clog2(`BOARD_COLS);
  localparam int ROW_W   = $clog2(`BOARD_ROWS);
  localparam int CELL_SH = $clog2(`CELL_PX);
  // grid rectangle edges
  localparam int GRID_X1 = `GRID_X0 + `BOARD_COLS * `CELL_PX;
  localparam int GRID_Y1 = `GRID_Y0 + `BOARD_ROWS * `CELL_PX;

  logic [9:0]       rel_x;
  logic [9:0]       rel_y;
  logic [COL_W-1:0] col;
  logic [ROW_W-1:0] row;
  logic             in_grid;

  // offset from the board origin
  assign rel_x = pix.x - 10'(`GRID_X0);
  assign rel_y = pix.y - 10'(`GRID_Y0);

  // cell under the pixel
  assign col = rel_x[CELL_SH +: COL_W];
  assign row = rel_y[CELL_SH +: ROW_W];

  assign in_grid = pix.active &&
                   (pix.x >= 10'(`GRID_X0)) && (pix.x < 10'(GRID_X1)) &&
                   (pix.y >= 10'(`GRID_Y0)) && (pix.y < 10'(GRID_Y1));

  // one register stage, black off the board
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      grid_color <= '0;
    end else begin
      grid_color <= in_grid ? board[row][col] : '0;
    end
  end

endmodule

`default_nettype wire

// ==== hw/score_renderer.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "display_macros.svh"

module score_renderer (
  input  wire logic                 clk,
  input  wire logic                 rst_n,
  vga_pixel_if.sink                 pix,
  input  wire logic [7:0]           score,
  input  wire display_pkg::color_t  score_fg,
  input  wire logic [13:0]          score_pos,
  output display_pkg::color_t       score_color,
  output logic                      score_hit
);

  // glyph size in font pixels
  localparam int GLYPH_W = 3;
  localparam int GLYPH_H = 5;
  // two digits plus a one font pixel gap
  localparam int BOX_W = (2 * GLYPH_W + 1) * `FONT_SCALE;
  localparam int BOX_H = GLYPH_H * `FONT_SCALE;

  logic [10:0] org_x;
  logic [10:0] org_y;
  logic [10:0] rel_x;
  logic [10:0] rel_y;
  logic [2:0]  font_x;
  logic [2:0]  font_y;
  logic [2:0]  glyph_col;
  logic [3:0]  nibble;
  logic [3:0]  bit_idx;
  logic [14:0] glyph;
  logic        in_box;
  logic        gap;
  logic        font_bit;

  // digit box origin in screen pixels, 11 bits so the far edge cannot wrap
  assign org_x = 11'(score_pos[5:0]) * 11'(`CELL_PX);
  assign org_y = 11'(score_pos[13:8]) * 11'(`CELL_PX);
  assign rel_x = 11'(pix.x) - org_x;
  assign rel_y = 11'(pix.y) - org_y;

  assign in_box = pix.active &&
                  (11'(pix.x) >= org_x) && (rel_x < 11'(BOX_W)) &&
                  (11'(pix.y) >= org_y) && (rel_y < 11'(BOX_H));

  // font pixel coordinates inside the box
  assign font_x = 3'(rel_x / 11'(`FONT_SCALE));
  assign font_y = 3'(rel_y / 11'(`FONT_SCALE));

  // left digit is the high nibble, then the gap column
  assign gap       = (font_x == 3'(GLYPH_W));
  assign nibble    = (font_x < 3'(GLYPH_W)) ? score[7:4] : score[3:0];
  assign glyph_col = (font_x < 3'(GLYPH_W)) ? font_x : font_x - 3'(GLYPH_W + 1);
  assign glyph     = display_pkg::hex_font[nibble];

  // row 0 in the top bits, msb at the left
  assign bit_idx  = 4'(14) - (4'(font_y) * 4'(GLYPH_W) + 4'(glyph_col));
  assign font_bit = in_box && !gap && glyph[bit_idx];

  // one register stage, hit flag travels with the colour
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      score_hit   <= 1'b0;
      score_color <= '0;
    end else begin
      score_hit   <= font_bit;
      score_color <= font_bit ? score_fg : '0;
    end
  end

endmodule

`default_nettype wire

// ==== hw/pixel_compositor.sv ====
`timescale 1ns/1ps
`default_nettype none

module pixel_compositor (
  input  wire logic                 clk,
  input  wire logic                 rst_n,
  vga_pixel_if.sink                 pix,
  input  wire display_pkg::color_t  grid_color,
  input  wire display_pkg::color_t  score_color,
  input  wire logic                 score_hit,
  output logic                      red,
  output logic                      green,
  output logic                      blue,
  output logic                      hsync,
  output logic                      vsync,
  output logic [9:0]                x,
  output logic [9:0]                y
);

  // stage 1 copies, aligned with the renderer outputs
  logic [9:0]          x_d1;
  logic [9:0]          y_d1;
  logic                hs_d1;
  logic                vs_d1;
  logic                act_d1;
  // stage 2 active flag, aligned with the outputs
  logic                act_d2;
  display_pkg::color_t merged;

  // score glyph wins over the board
  assign merged = score_hit ? score_color : grid_color;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      x_d1   <= '0;
      y_d1   <= '0;
      hs_d1  <= 1'b1;
      vs_d1  <= 1'b1;
      act_d1 <= 1'b0;
      x      <= '0;
      y      <= '0;
      hsync  <= 1'b1;
      vsync  <= 1'b1;
      act_d2 <= 1'b0;
      red    <= 1'b0;
      green  <= 1'b0;
      blue   <= 1'b0;
    end else begin
      x_d1   <= pix.x;
      y_d1   <= pix.y;
      hs_d1  <= pix.hsync;
      vs_d1  <= pix.vsync;
      act_d1 <= pix.active;
      x      <= x_d1;
      y      <= y_d1;
      hsync  <= hs_d1;
      vsync  <= vs_d1;
      act_d2 <= act_d1;
      // colour bits ordered red, green, blue
      {red, green, blue} <= merged;
    end
  end

  // both renderers must blank outside the visible area
  a_blank: assert property (@(posedge clk) disable iff (!rst_n)
    !act_d2 |-> ({red, green, blue} == 3'b000));

endmodule

`default_nettype wire

// ==== hw/tetris_display_top.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "display_macros.svh"

module tetris_display_top (
  input  wire logic                     hz100,
  input  wire logic                     rst_n,
  // apb host port
  input  wire logic                     psel,
  input  wire logic                     penable,
  input  wire logic                     pwrite,
  input  wire logic [`APB_ADDR_W-1:0]   paddr,
  input  wire logic [31:0]              pwdata,
  output logic      [31:0]              prdata,
  output logic                          pready,
  output logic                          pslverr,
  // vga out, all aligned to one pixel
  output logic                          red,
  output logic                          green,
  output logic                          blue,
  output logic                          hsync,
  output logic                          vsync,
  output logic      [9:0]               x,
  output logic      [9:0]               y
);

  // register file to renderers
  display_pkg::board_t board;
  logic [7:0]          score;
  display_pkg::color_t score_fg;
  logic [13:0]         score_pos;

  // renderer layers
  display_pkg::color_t grid_color;
  display_pkg::color_t score_color;
  logic                score_hit;

  // stage 0 pixel bus
  vga_pixel_if pix ();

  vga_timing u_timing (.clk(hz100), .rst_n(rst_n), .pix(pix));

  apb_regs u_regs (
    .clk(hz100), .rst_n(rst_n), .psel(psel), .penable(penable), .pwrite(pwrite),
    .paddr(paddr), .pwdata(pwdata), .prdata(prdata), .pready(pready),
    .pslverr(pslverr), .board(board), .score(score), .score_fg(score_fg),
    .score_pos(score_pos)
  );

  playfield_renderer u_playfield (
    .clk(hz100), .rst_n(rst_n), .pix(pix), .board(board), .grid_color(grid_color)
  );

  score_renderer u_score (
    .clk(hz100), .rst_n(rst_n), .pix(pix), .score(score), .score_fg(score_fg),
    .score_pos(score_pos), .score_color(score_color), .score_hit(score_hit)
  );

  pixel_compositor u_comp (
    .clk(hz100), .rst_n(rst_n), .pix(pix), .grid_color(grid_color),
    .score_color(score_color), .score_hit(score_hit), .red(red), .green(green),
    .blue(blue), .hsync(hsync), .vsync(vsync), .x(x), .y(y)
  );

endmodule

`default_nettype wire

// ==== verif/tb_clock.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
  output logic clk,
  output logic rst_n
);

  // 4 ns pixel clock
  localparam time HALF_PERIOD = 2ns;

  initial begin
    clk = 1'b0;
    forever #(HALF_PERIOD) clk = ~clk;
  end

  // reset held for 4 rising edges, released just after the last one
  initial begin
    rst_n = 1'b0;
    repeat (4) @(posedge clk);
    #1 rst_n = 1'b1;
  end

endmodule

`default_nettype wire

// ==== verif/tb_tetris_display.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "display_macros.svh"

module tb_tetris_display;

  // 8 frames covers reset, registers, sync and four sampling passes
  localparam int TIMEOUT_CYCLES = 8 * `H_TOTAL * `V_TOTAL;

  logic                   clk;
  logic                   rst_n;
  logic                   psel;
  logic                   penable;
  logic                   pwrite;
  logic [`APB_ADDR_W-1:0] paddr;
  logic [31:0]            pwdata;
  logic [31:0]            prdata;
  logic                   pready;
  logic                   pslverr;
  logic                   red;
  logic                   green;
  logic                   blue;
  logic                   hsync;
  logic                   vsync;
  logic [9:0]             x;
  logic [9:0]             y;

  // reference model of the register contents
  logic [2:0] cells [0:`BOARD_ROWS-1][0:`BOARD_COLS-1];
  logic [7:0] score_val;
  logic [2:0] score_fg_val;
  int         pos_col;
  int         pos_row;

  int cycle_cnt = 0;

  tb_clock u_clock (.clk(clk), .rst_n(rst_n));

  tetris_display_top dut (
    .hz100(clk), .rst_n(rst_n), .psel(psel), .penable(penable), .pwrite(pwrite),
    .paddr(paddr), .pwdata(pwdata), .prdata(prdata), .pready(pready),
    .pslverr(pslverr), .red(red), .green(green), .blue(blue), .hsync(hsync),
    .vsync(vsync), .x(x), .y(y)
  );

  // watchdog
  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("timeout: the tests did not finish within %0d clock cycles", TIMEOUT_CYCLES);
      $display("STATUS: FAIL");
      $fatal(1, "watchdog expired");
    end
  end

  task automatic check_eq(input logic [31:0] actual, input logic [31:0] expected,
                          input string msg);
    if (actual !== expected) begin
      $display("error at %0t ns: %s, got 0x%0h expected 0x%0h", $time, msg, actual,
               expected);
      $display("STATUS: FAIL");
      $fatal(1, "value mismatch");
    end
  endtask

  // sample point 1 ns after the rising edge
  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic apb_write(input logic [`APB_ADDR_W-1:0] addr, input logic [31:0] data,
                           output logic err);
    next_cycle();
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = 1'b1;
    paddr   = addr;
    pwdata  = data;
    next_cycle();
    penable = 1'b1;
    // let the combinational response settle
    #1;
    err = pslverr;
    check_eq(32'(pready), 32'd1, "pready in write access");
    next_cycle();
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic apb_read(input logic [`APB_ADDR_W-1:0] addr, output logic [31:0] data,
                          output logic err);
    next_cycle();
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = addr;
    next_cycle();
    penable = 1'b1;
    #1;
    data = prdata;
    err  = pslverr;
    check_eq(32'(pready), 32'd1, "pready in read access");
    next_cycle();
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  // waits for the output pixel and needs targets in raster order
  task automatic sample_pixel(input int tx, input int ty, output logic [2:0] color);
    next_cycle();
    while (!(x == 10'(tx) && y == 10'(ty))) begin
      next_cycle();
    end
    color = {red, green, blue};
  endtask

  function automatic logic [31:0] pack_row(input int r);
    logic [31:0] word;
    word = '0;
    // column 0 in the low bits
    for (int c = 0; c < `BOARD_COLS; c++) begin
      word[c*3 +: 3] = cells[r][c];
    end
    return word;
  endfunction

  // colour the screen should show at one pixel
  function automatic logic [2:0] expected_color(input int px, input int py);
    int         ox;
    int         oy;
    int         fx;
    int         fy;
    int         gcol;
    logic [3:0] nib;
    logic [14:0] glyph;
    if (px >= `H_ACTIVE || py >= `V_ACTIVE) begin
      return 3'b000;
    end
    ox = pos_col * `CELL_PX;
    oy = pos_row * `CELL_PX;
    // two 3-wide glyphs with a one font pixel gap
    if (px >= ox && px < ox + 7 * `FONT_SCALE && py >= oy && py < oy + 5 * `FONT_SCALE) begin
      fx = (px - ox) / `FONT_SCALE;
      fy = (py - oy) / `FONT_SCALE;
      if (fx != 3) begin
        nib   = (fx < 3) ? score_val[7:4] : score_val[3:0];
        gcol  = (fx < 3) ? fx : fx - 4;
        glyph = display_pkg::hex_font[nib];
        if (glyph[14 - (fy * 3 + gcol)]) begin
          return score_fg_val;
        end
      end
    end
    // board below the glyph layer
    if (px >= `GRID_X0 && px < `GRID_X0 + `BOARD_COLS * `CELL_PX &&
        py >= `GRID_Y0 && py < `GRID_Y0 + `BOARD_ROWS * `CELL_PX) begin
      return cells[(py - `GRID_Y0) / `CELL_PX][(px - `GRID_X0) / `CELL_PX];
    end
    return 3'b000;
  endfunction

  task automatic write_board();
    logic err;
    for (int r = 0; r < `BOARD_ROWS; r++) begin
      apb_write(`APB_ADDR_W'(`ADDR_ROW0 + r), pack_row(r), err);
      check_eq(32'(err), 32'd0, $sformatf("pslverr on row %0d write", r));
    end
  endtask

  task automatic write_score_regs();
    logic err;
    apb_write(`APB_ADDR_W'(`ADDR_SCORE), 32'(score_val), err);
    check_eq(32'(err), 32'd0, "pslverr on score write");
    apb_write(`APB_ADDR_W'(`ADDR_SCORE_COLOR), 32'(score_fg_val), err);
    check_eq(32'(err), 32'd0, "pslverr on colour write");
    apb_write(`APB_ADDR_W'(`ADDR_SCORE_POS), (32'(pos_row) << 8) | 32'(pos_col), err);
    check_eq(32'(err), 32'd0, "pslverr on position write");
  endtask

  // read every mapped register against the model
  task automatic verify_registers();
    logic [31:0] rd;
    logic        err;
    for (int r = 0; r < `BOARD_ROWS; r++) begin
      apb_read(`APB_ADDR_W'(`ADDR_ROW0 + r), rd, err);
      check_eq(32'(err), 32'd0, $sformatf("pslverr on row %0d read", r));
      check_eq(rd, pack_row(r), $sformatf("row %0d readback", r));
    end
    apb_read(`APB_ADDR_W'(`ADDR_SCORE), rd, err);
    check_eq(rd, 32'(score_val), "score readback");
    apb_read(`APB_ADDR_W'(`ADDR_SCORE_COLOR), rd, err);
    check_eq(rd, 32'(score_fg_val), "score colour readback");
    apb_read(`APB_ADDR_W'(`ADDR_SCORE_POS), rd, err);
    check_eq(rd, (32'(pos_row) << 8) | 32'(pos_col), "score position readback");
  endtask

  task automatic reset_readback();
    next_cycle();
    check_eq(32'(hsync), 32'd1, "hsync after reset");
    check_eq(32'(vsync), 32'd1, "vsync after reset");
    check_eq(32'({red, green, blue}), 32'd0, "colour after reset");
    check_eq(32'(pslverr), 32'd0, "pslverr after reset");
    verify_registers();
  endtask

  task automatic register_access();
    logic [31:0] rd;
    logic        err;
    for (int r = 0; r < `BOARD_ROWS; r++) begin
      for (int c = 0; c < `BOARD_COLS; c++) begin
        cells[r][c] = 3'($urandom);
      end
    end
    score_val    = 8'($urandom);
    score_fg_val = 3'($urandom);
    pos_col      = int'($urandom_range(0, 63));
    pos_row      = int'($urandom_range(0, 63));
    write_board();
    write_score_regs();
    verify_registers();
    // hole in the map
    apb_write(`APB_ADDR_W'('h30), 32'hffff_ffff, err);
    check_eq(32'(err), 32'd1, "pslverr on unmapped write");
    verify_registers();
    apb_read(`APB_ADDR_W'('h30), rd, err);
    check_eq(32'(err), 32'd1, "pslverr on unmapped read");
    check_eq(rd, 32'd0, "unmapped readback");
  endtask

  task automatic sync_timing();
    int low_cnt;
    int period;
    next_cycle();
    // align to a falling hsync
    while (hsync !== 1'b1) next_cycle();
    while (hsync !== 1'b0) next_cycle();
    check_eq(32'(x), 32'(`H_ACTIVE + `H_FP), "x at hsync start");
    low_cnt = 0;
    while (hsync === 1'b0) begin
      next_cycle();
      low_cnt++;
    end
    period = low_cnt;
    while (hsync === 1'b1) begin
      next_cycle();
      period++;
    end
    check_eq(32'(low_cnt), 32'(`H_SYNC), "hsync low width");
    check_eq(32'(period), 32'(`H_TOTAL), "hsync period");
    // vsync pulse width counted in clocks
    while (vsync !== 1'b1) next_cycle();
    while (vsync !== 1'b0) next_cycle();
    check_eq(32'(y), 32'(`V_ACTIVE + `V_FP), "y at vsync start");
    check_eq(32'(x), 32'd0, "x at vsync start");
    low_cnt = 0;
    while (vsync === 1'b0) begin
      next_cycle();
      low_cnt++;
    end
    check_eq(32'(low_cnt), 32'(`V_SYNC * `H_TOTAL), "vsync low width");
  endtask

  task automatic check_black(input int px, input int py);
    logic [2:0] color;
    sample_pixel(px, py, color);
    check_eq(32'(color), 32'd0, $sformatf("black at %0d,%0d", px, py));
  endtask

  task automatic playfield_cells();
    logic [2:0] color;
    int         px;
    int         py;
    // score box off the right edge
    pos_col = 45;
    pos_row = 0;
    write_score_regs();
    // every cell lit
    for (int r = 0; r < `BOARD_ROWS; r++) begin
      for (int c = 0; c < `BOARD_COLS; c++) begin
        cells[r][c] = 3'($urandom_range(1, 7));
      end
    end
    write_board();
    // centre of every cell in raster order
    for (int r = 0; r < `BOARD_ROWS; r++) begin
      for (int c = 0; c < `BOARD_COLS; c++) begin
        px = `GRID_X0 + c * `CELL_PX + `CELL_PX / 2;
        py = `GRID_Y0 + r * `CELL_PX + `CELL_PX / 2;
        sample_pixel(px, py, color);
        check_eq(32'(color), 32'(expected_color(px, py)), $sformatf("cell %0d,%0d", r, c));
      end
    end
    // one pixel past each grid edge and then both blanking regions
    check_black(300, `GRID_Y0 - 1);
    check_black(`GRID_X0 - 1, 100);
    check_black(`GRID_X0 + `BOARD_COLS * `CELL_PX, 100);
    check_black(700, 200);
    check_black(300, `GRID_Y0 + `BOARD_ROWS * `CELL_PX);
    check_black(100, 500);
  endtask

  task automatic score_overlay();
    logic [2:0] color;
    int         px;
    int         py;
    score_val    = 8'($urandom);
    score_fg_val = 3'($urandom_range(1, 7));
    // box fully over the board
    pos_col = 15 + int'($urandom_range(0, 7));
    pos_row = 5 + int'($urandom_range(0, 17));
    write_score_regs();
    // centre of each font pixel including the gap column
    for (int fy = 0; fy < 5; fy++) begin
      for (int fx = 0; fx < 7; fx++) begin
        px = pos_col * `CELL_PX + fx * `FONT_SCALE + `FONT_SCALE / 2;
        py = pos_row * `CELL_PX + fy * `FONT_SCALE + `FONT_SCALE / 2;
        sample_pixel(px, py, color);
        check_eq(32'(color), 32'(expected_color(px, py)),
                 $sformatf("score 0x%0h font pixel %0d,%0d", score_val, fx, fy));
      end
    end
  endtask

  initial begin
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = '0;
    pwdata  = '0;
    // model matches the reset contents
    for (int r = 0; r < `BOARD_ROWS; r++) begin
      for (int c = 0; c < `BOARD_COLS; c++) begin
        cells[r][c] = 3'b000;
      end
    end
    score_val    = '0;
    score_fg_val = '0;
    pos_col      = 0;
    pos_row      = 0;
    void'($urandom(32'he75a2492));
    wait (rst_n === 1'b1);
    reset_readback();
    register_access();
    sync_timing();
    playfield_cells();
    score_overlay();
    score_overlay();
    $display("STATUS: PASS");
    $finish;
  end

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+hw
hw/display_pkg.sv
hw/vga_pixel_if.sv
hw/vga_timing.sv
hw/apb_regs.sv
hw/playfield_renderer.sv
hw/score_renderer.sv
hw/pixel_compositor.sv
hw/tetris_display_top.sv
verif/tb_clock.sv
verif/tb_tetris_display.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --assert -f verilog.f --top-module tb_tetris_display \
  -Mdir obj_dir -o sim_tb

out=$(./obj_dir/sim_tb 2>&1) || true
echo "$out"

# exit status follows the pass line
echo "$out" | grep -qx "STATUS: PASS"
